// ==== Bender.yml ====
package:
  name: frame_buffer

sources:
  - logic/fb_pkg.sv
  - logic/video_timing.sv
  - logic/io_bus.sv
  - logic/vpu_cursor.sv
  - logic/pixel_store.sv
  - logic/scanout.sv
  - logic/frame_buffer_top.sv
  - target: simulation
    files:
      - tb/fb_tests.sv
      - tb/frame_buffer_tb.sv

// ==== flist.f ====
logic/fb_pkg.sv
logic/video_timing.sv
logic/io_bus.sv
logic/vpu_cursor.sv
logic/pixel_store.sv
logic/scanout.sv
logic/frame_buffer_top.sv
tb/fb_tests.sv
tb/frame_buffer_tb.sv

// ==== logic/fb_pkg.sv ====
`default_nettype none

package fb_pkg;

  // Bus and pixel data types
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  pixel_t;
  typedef logic [8:0]  coord_t;

  // High byte is the row part, low byte the column part
  typedef logic [15:0] cursor_t;

  // Scratch RAM occupies 0x00 to 0x3F
  localparam int RAM_WORDS = 64;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // Read-only status registers
  localparam byte_t REG_HPOS  = 8'h40;
  localparam byte_t REG_VPOS  = 8'h41;
  localparam byte_t REG_FLAGS = 8'h42;
  localparam byte_t REG_PIXEL = 8'h43;

  // VPU write registers
  localparam byte_t REG_CURSOR_HI   = 8'h44;
  localparam byte_t REG_CURSOR_LO   = 8'h45;
  localparam byte_t REG_PIXEL_WRITE = 8'h46;
  localparam byte_t REG_MOVE        = 8'h47;

  // Bit positions in the REG_FLAGS byte, upper bits read as zero
  localparam int FLAG_DISPLAY = 0;
  localparam int FLAG_HPADDLE = 1;
  localparam int FLAG_VPADDLE = 2;
  localparam int FLAG_HSYNC   = 3;
  localparam int FLAG_VSYNC   = 4;

endpackage

`default_nettype wire

// ==== logic/frame_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top
  import fb_pkg::*;
#(
  parameter int H_ACTIVE     = 256,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 304,
  parameter int H_TOTAL      = 320,
  parameter int V_ACTIVE     = 240,
  parameter int V_SYNC_START = 244,
  parameter int V_SYNC_END   = 247,
  parameter int V_TOTAL      = 262,
  parameter int PIX_AW       = 16
) (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire byte_t address,
  input  wire byte_t wdata,
  input  wire logic  write,
  output byte_t      rdata,
  input  wire logic  hpaddle,
  input  wire logic  vpaddle,
  output logic       hsync,
  output logic       vsync,
  output pixel_t     rgb
);

  coord_t  hpos;
  coord_t  vpos;
  logic    display_on;
  logic    vblank;
  logic    cursor_hi_load;
  logic    cursor_lo_load;
  logic    pair_write;
  logic    cursor_move;
  cursor_t cursor;
  logic    pixel_we;
  byte_t   pixel_pair;
  byte_t   pair_rdata;
  cursor_t scan_addr;
  pixel_t  scan_pixel;

  video_timing #(
    .H_ACTIVE     (H_ACTIVE),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_ACTIVE     (V_ACTIVE),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) u_timing (
    .clk        (clk),
    .reset      (reset),
    .hpos       (hpos),
    .vpos       (vpos),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .vblank     (vblank)
  );

  io_bus u_bus (
    .clk            (clk),
    .address        (address),
    .wdata          (wdata),
    .write          (write),
    .rdata          (rdata),
    .hpos           (hpos),
    .vpos           (vpos),
    .hsync          (hsync),
    .vsync          (vsync),
    .display_on     (display_on),
    .hpaddle        (hpaddle),
    .vpaddle        (vpaddle),
    .pair_rdata     (pair_rdata),
    .cursor_hi_load (cursor_hi_load),
    .cursor_lo_load (cursor_lo_load),
    .pair_write     (pair_write),
    .cursor_move    (cursor_move)
  );

  vpu_cursor u_cursor (
    .clk            (clk),
    .reset          (reset),
    .wdata          (wdata),
    .cursor_hi_load (cursor_hi_load),
    .cursor_lo_load (cursor_lo_load),
    .pair_write     (pair_write),
    .cursor_move    (cursor_move),
    .cursor         (cursor),
    .pixel_we       (pixel_we),
    .pixel_pair     (pixel_pair)
  );

  pixel_store #(
    .PIX_AW (PIX_AW)
  ) u_store (
    .clk        (clk),
    .pixel_we   (pixel_we),
    .cursor     (cursor),
    .pixel_pair (pixel_pair),
    .pair_rdata (pair_rdata),
    .scan_addr  (scan_addr),
    .scan_pixel (scan_pixel)
  );

  scanout u_scanout (
    .clk        (clk),
    .reset      (reset),
    .display_on (display_on),
    .vblank     (vblank),
    .scan_addr  (scan_addr),
    .scan_pixel (scan_pixel),
    .rgb        (rgb)
  );

endmodule

`default_nettype wire

// ==== logic/io_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_bus
  import fb_pkg::*;
(
  input  wire logic   clk,
  input  wire byte_t  address,
  input  wire byte_t  wdata,
  input  wire logic   write,
  output byte_t       rdata,
  input  wire coord_t hpos,
  input  wire coord_t vpos,
  input  wire logic   hsync,
  input  wire logic   vsync,
  input  wire logic   display_on,
  input  wire logic   hpaddle,
  input  wire logic   vpaddle,
  input  wire byte_t  pair_rdata,
  output logic        cursor_hi_load,
  output logic        cursor_lo_load,
  output logic        pair_write,
  output logic        cursor_move
);

  byte_t ram [RAM_WORDS];

  logic              ram_sel;
  logic              ram_write;
  logic [RAM_AW-1:0] ram_addr;
  byte_t             flags;

  assign ram_sel   = (address < byte_t'(RAM_WORDS));
  assign ram_addr  = address[RAM_AW-1:0];
  assign ram_write = write && ram_sel;

  // One strobe per VPU register, other addresses fall through
  assign cursor_hi_load = write && (address == REG_CURSOR_HI);
  assign cursor_lo_load = write && (address == REG_CURSOR_LO);
  assign pair_write     = write && (address == REG_PIXEL_WRITE);
  assign cursor_move    = write && (address == REG_MOVE);

  always_ff @(posedge clk) begin
    if (ram_write) begin
      ram[ram_addr] <= wdata;
    end
  end

  always_comb begin
    flags               = '0;
    flags[FLAG_DISPLAY] = display_on;
    flags[FLAG_HPADDLE] = hpaddle;
    flags[FLAG_VPADDLE] = vpaddle;
    flags[FLAG_HSYNC]   = hsync;
    flags[FLAG_VSYNC]   = vsync;
  end

  // Read mux, unmapped addresses give zero
  always_comb begin
    if (ram_sel) begin
      rdata = ram[ram_addr];
    end else begin
      case (address)
        REG_HPOS:  rdata = hpos[7:0];
        REG_VPOS:  rdata = vpos[7:0];
        REG_FLAGS: rdata = flags;
        REG_PIXEL: rdata = pair_rdata;
        default:   rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/pixel_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_store
  import fb_pkg::*;
#(
  parameter int PIX_AW = 16
) (
  input  wire logic    clk,
  input  wire logic    pixel_we,
  input  wire cursor_t cursor,
  input  wire byte_t   pixel_pair,
  output byte_t        pair_rdata,
  input  wire cursor_t scan_addr,
  output pixel_t       scan_pixel
);

  pixel_t mem [2**PIX_AW];

  logic [PIX_AW-1:0] pair_addr;
  logic [PIX_AW-1:0] pair_next;
  logic [PIX_AW-1:0] scan_index;

  assign pair_addr  = cursor[PIX_AW-1:0];
  assign pair_next  = pair_addr + 1'b1;
  assign scan_index = scan_addr[PIX_AW-1:0];

  // High nibble first, then its neighbour
  always_ff @(posedge clk) begin
    if (pixel_we) begin
      mem[pair_addr] <= pixel_pair[7:4];
      mem[pair_next] <= pixel_pair[3:0];
    end
  end

  assign pair_rdata = {mem[pair_addr], mem[pair_next]};

  assign scan_pixel = mem[scan_index];

endmodule

`default_nettype wire

// ==== logic/scanout.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanout
  import fb_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   display_on,
  input  wire logic   vblank,
  output cursor_t     scan_addr,
  input  wire pixel_t scan_pixel,
  output pixel_t      rgb
);

  cursor_t read_ptr;

  assign scan_addr = read_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      read_ptr <= '0;
      rgb      <= '0;
    end else if (display_on) begin
      rgb      <= scan_pixel;
      read_ptr <= read_ptr + 1'b1;
    end else begin
      // Black outside the active area
      rgb <= '0;
      if (vblank) begin
        read_ptr <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing
  import fb_pkg::*;
#(
  parameter int H_ACTIVE     = 256,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 304,
  parameter int H_TOTAL      = 320,
  parameter int V_ACTIVE     = 240,
  parameter int V_SYNC_START = 244,
  parameter int V_SYNC_END   = 247,
  parameter int V_TOTAL      = 262
) (
  input  wire logic   clk,
  input  wire logic   reset,
  output coord_t      hpos,
  output coord_t      vpos,
  output logic        hsync,
  output logic        vsync,
  output logic        display_on,
  output logic        vblank
);

  localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
  localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (hpos == H_LAST);
  assign v_wrap = (vpos == V_LAST);

  // Horizontal counter runs every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (h_wrap) begin
      hpos <= '0;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // Vertical counter steps once per line
  always_ff @(posedge clk) begin
    if (reset) begin
      vpos <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 1'b1;
      end
    end
  end

  assign hsync = (hpos >= coord_t'(H_SYNC_START)) && (hpos < coord_t'(H_SYNC_END));
  assign vsync = (vpos >= coord_t'(V_SYNC_START)) && (vpos < coord_t'(V_SYNC_END));

  assign display_on = (hpos < coord_t'(H_ACTIVE)) && (vpos < coord_t'(V_ACTIVE));
  assign vblank     = (vpos >= coord_t'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== logic/vpu_cursor.sv ====
`timescale 1ns/1ps
`default_nettype none

module vpu_cursor
  import fb_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire byte_t wdata,
  input  wire logic  cursor_hi_load,
  input  wire logic  cursor_lo_load,
  input  wire logic  pair_write,
  input  wire logic  cursor_move,
  output cursor_t    cursor,
  output logic       pixel_we,
  output byte_t      pixel_pair
);

  byte_t step_hi;
  byte_t step_lo;
  byte_t moved_hi;
  byte_t moved_lo;

  // Signed nibble steps, one per cursor byte
  assign step_hi = {{4{wdata[7]}}, wdata[7:4]};
  assign step_lo = {{4{wdata[3]}}, wdata[3:0]};

  // Each byte wraps on its own
  assign moved_hi = cursor[15:8] + step_hi;
  assign moved_lo = cursor[7:0] + step_lo;

  always_ff @(posedge clk) begin
    if (reset) begin
      cursor <= '0;
    end else if (cursor_hi_load) begin
      cursor[15:8] <= wdata;
    end else if (cursor_lo_load) begin
      cursor[7:0] <= wdata;
    end else if (pair_write) begin
      cursor <= cursor + 16'd2;
    end else if (cursor_move) begin
      cursor <= {moved_hi, moved_lo};
    end
  end

  // Pair is written at the old cursor in the strobe cycle
  assign pixel_we   = pair_write;
  assign pixel_pair = wdata;

endmodule

`default_nettype wire

// ==== tb/fb_tests.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_tests
  import fb_pkg::*;
#(
  parameter int H_ACTIVE       = 16,
  parameter int H_SYNC_START   = 18,
  parameter int H_SYNC_END     = 20,
  parameter int H_TOTAL        = 24,
  parameter int V_ACTIVE       = 16,
  parameter int V_SYNC_START   = 17,
  parameter int V_SYNC_END     = 19,
  parameter int V_TOTAL        = 20,
  parameter int PIX_AW         = 8,
  parameter int BEAM_READS     = 600,
  parameter int RAM_OPS        = 300,
  parameter int UNMAPPED_READS = 40,
  parameter int CURSOR_STEPS   = 150,
  parameter int PAIR_COUNT     = 60
) (
  input  wire logic   clk,
  input  wire logic   reset,
  output byte_t       address,
  output byte_t       wdata,
  output logic        write,
  input  wire byte_t  rdata,
  output logic        hpaddle,
  output logic        vpaddle,
  input  wire logic   hsync,
  input  wire logic   vsync,
  input  wire pixel_t rgb,
  output logic        done
);

  localparam int PIX_WORDS = 2**PIX_AW;
  localparam int PIX_MASK  = PIX_WORDS - 1;

  integer  seed;
  byte_t   ram_model [RAM_WORDS];
  pixel_t  pix_model [PIX_WORDS];
  cursor_t cur_model;
  int      beam_h;
  int      beam_v;
  int      last_h;
  int      last_v;

  // Reference beam and its position one cycle back
  always @(posedge clk) begin
    if (reset) begin
      beam_h <= 0;
      beam_v <= 0;
      last_h <= 0;
      last_v <= 0;
    end else begin
      last_h <= beam_h;
      last_v <= beam_v;
      if (beam_h == H_TOTAL - 1) begin
        beam_h <= 0;
        beam_v <= (beam_v == V_TOTAL - 1) ? 0 : beam_v + 1;
      end else begin
        beam_h <= beam_h + 1;
      end
    end
  end

  function automatic byte_t random_byte();
    return byte_t'($random(seed));
  endfunction

  function automatic logic in_window(int pos, int lo, int hi);
    return (pos >= lo) && (pos < hi);
  endfunction

  function automatic logic active_at(int h, int v);
    return (h < H_ACTIVE) && (v < V_ACTIVE);
  endfunction

  // Two's complement value of a 4-bit step
  function automatic int nibble_step(pixel_t n);
    return (n >= 8) ? int'(n) - 16 : int'(n);
  endfunction

  function automatic byte_t pair_at(cursor_t c);
    return {pix_model[int'(c) & PIX_MASK], pix_model[(int'(c) + 1) & PIX_MASK]};
  endfunction

  task automatic update_model(byte_t a, byte_t d);
    int hi;
    int lo;
    if (a < byte_t'(RAM_WORDS)) begin
      ram_model[a[RAM_AW-1:0]] = d;
    end else if (a == REG_CURSOR_HI) begin
      cur_model[15:8] = d;
    end else if (a == REG_CURSOR_LO) begin
      cur_model[7:0] = d;
    end else if (a == REG_PIXEL_WRITE) begin
      pix_model[int'(cur_model) & PIX_MASK] = d[7:4];
      pix_model[(int'(cur_model) + 1) & PIX_MASK] = d[3:0];
      cur_model = cur_model + 16'd2;
    end else if (a == REG_MOVE) begin
      hi = (int'(cur_model[15:8]) + nibble_step(d[7:4])) & 255;
      lo = (int'(cur_model[7:0]) + nibble_step(d[3:0])) & 255;
      cur_model = {hi[7:0], lo[7:0]};
    end
  endtask

  task automatic write_reg(byte_t a, byte_t d);
    @(posedge clk);
    #1;
    address = a;
    wdata   = d;
    write   = 1'b1;
    @(posedge clk);
    #1;
    write = 1'b0;
    update_model(a, d);
  endtask

  task automatic read_reg(byte_t a, output byte_t d);
    @(posedge clk);
    #1;
    address = a;
    #2;
    d = rdata;
  endtask

  task automatic fill_pixels();
    write_reg(REG_CURSOR_HI, 8'h00);
    write_reg(REG_CURSOR_LO, 8'h00);
    for (int i = 0; i < PIX_WORDS / 2; i++) begin
      write_reg(REG_PIXEL_WRITE, random_byte());
    end
  endtask

  task automatic scan_beam_status();
    byte_t reg_addr;
    byte_t r;
    byte_t flags;
    for (int i = 0; i < BEAM_READS; i++) begin
      @(posedge clk);
      #1;
      r = random_byte();
      reg_addr = REG_HPOS + byte_t'(r[7:2] % 3);
      address = reg_addr;
      hpaddle = r[0];
      vpaddle = r[1];
      #2;
      flags = '0;
      flags[FLAG_DISPLAY] = active_at(beam_h, beam_v);
      flags[FLAG_HPADDLE] = r[0];
      flags[FLAG_VPADDLE] = r[1];
      flags[FLAG_HSYNC]   = in_window(beam_h, H_SYNC_START, H_SYNC_END);
      flags[FLAG_VSYNC]   = in_window(beam_v, V_SYNC_START, V_SYNC_END);
      if (reg_addr == REG_HPOS) begin
        frame_buffer_tb.check_byte(rdata, byte_t'(beam_h), "REG_HPOS read");
      end else if (reg_addr == REG_VPOS) begin
        frame_buffer_tb.check_byte(rdata, byte_t'(beam_v), "REG_VPOS read");
      end else begin
        frame_buffer_tb.check_byte(rdata, flags, "REG_FLAGS read");
      end
      frame_buffer_tb.check_byte({6'b0, hsync, vsync},
                                 {6'b0, flags[FLAG_HSYNC], flags[FLAG_VSYNC]}, "sync pins");
    end
  endtask

  task automatic exercise_scratch_ram();
    byte_t a;
    byte_t d;
    byte_t op;
    byte_t got;
    for (int i = 0; i < RAM_WORDS; i++) begin
      write_reg(byte_t'(i), random_byte());
    end
    for (int i = 0; i < RAM_OPS; i++) begin
      a = random_byte() & 8'h3f;
      d = random_byte();
      op = random_byte();
      if (op[0]) begin
        write_reg(a, d);
      end else begin
        read_reg(a, got);
        frame_buffer_tb.check_byte(got, ram_model[a[RAM_AW-1:0]], "scratch RAM read");
      end
    end
    // Write-only registers and everything above them read as zero
    for (int i = 0; i < UNMAPPED_READS; i++) begin
      a = random_byte();
      if (a < REG_CURSOR_HI) begin
        a = a + REG_CURSOR_HI;
      end
      read_reg(a, got);
      frame_buffer_tb.check_byte(got, 8'h00, "unmapped read");
    end
  endtask

  task automatic walk_cursor();
    byte_t sel;
    byte_t got;
    fill_pixels();
    for (int i = 0; i < CURSOR_STEPS; i++) begin
      sel = random_byte();
      case (sel[1:0])
        2'd0:    write_reg(REG_CURSOR_HI, random_byte());
        2'd1:    write_reg(REG_CURSOR_LO, random_byte());
        default: write_reg(REG_MOVE, random_byte());
      endcase
      read_reg(REG_PIXEL, got);
      frame_buffer_tb.check_byte(got, pair_at(cur_model), "pixel pair after cursor step");
    end
  endtask

  task automatic stream_pairs();
    cursor_t start;
    byte_t   got;
    start = {random_byte(), random_byte()};
    write_reg(REG_CURSOR_HI, start[15:8]);
    write_reg(REG_CURSOR_LO, start[7:0]);
    for (int i = 0; i < PAIR_COUNT; i++) begin
      write_reg(REG_PIXEL_WRITE, random_byte());
    end
    write_reg(REG_CURSOR_HI, start[15:8]);
    write_reg(REG_CURSOR_LO, start[7:0]);
    // Rewrite the expected pair to step the cursor without changing memory
    for (int i = 0; i < PAIR_COUNT; i++) begin
      read_reg(REG_PIXEL, got);
      frame_buffer_tb.check_byte(got, pair_at(cur_model), "streamed pair readback");
      write_reg(REG_PIXEL_WRITE, pair_at(cur_model));
    end
  endtask

  task automatic watch_scanout();
    pixel_t expect_rgb;
    fill_pixels();
    do begin
      @(posedge clk);
      #3;
    end while (beam_v < V_ACTIVE);
    for (int i = 0; i < H_TOTAL * V_TOTAL; i++) begin
      @(posedge clk);
      #3;
      if (active_at(last_h, last_v)) begin
        expect_rgb = pix_model[(last_v * H_ACTIVE + last_h) & PIX_MASK];
      end else begin
        expect_rgb = '0;
      end
      frame_buffer_tb.check_pixel(rgb, expect_rgb, "rgb output");
    end
  endtask

  initial begin
    seed      = 32'h96ce26f4;
    address   = '0;
    wdata     = '0;
    write     = 1'b0;
    hpaddle   = 1'b0;
    vpaddle   = 1'b0;
    done      = 1'b0;
    cur_model = '0;
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    scan_beam_status();
    exercise_scratch_ram();
    walk_cursor();
    stream_pairs();
    watch_scanout();
    done = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/frame_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb
  import fb_pkg::*;
();

  localparam int H_ACTIVE     = 16;
  localparam int H_SYNC_START = 18;
  localparam int H_SYNC_END   = 20;
  localparam int H_TOTAL      = 24;
  localparam int V_ACTIVE     = 16;
  localparam int V_SYNC_START = 17;
  localparam int V_SYNC_END   = 19;
  localparam int V_TOTAL      = 20;
  localparam int PIX_AW       = 8;

  localparam int CLK_PERIOD     = 4;
  localparam int BEAM_READS     = 600;
  localparam int RAM_OPS        = 300;
  localparam int UNMAPPED_READS = 40;
  localparam int CURSOR_STEPS   = 150;
  localparam int PAIR_COUNT     = 60;

  // Writes take two cycles, reads one
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int FILL_CYCLES  = 2 * (2 + (2**PIX_AW) / 2);
  localparam int TEST_CYCLES  = BEAM_READS + 2 * RAM_WORDS + 2 * RAM_OPS + UNMAPPED_READS
                              + FILL_CYCLES + 3 * CURSOR_STEPS + 8 + 5 * PAIR_COUNT
                              + FILL_CYCLES + 2 * FRAME_CYCLES;
  localparam int WATCHDOG_CYCLES = 4 + TEST_CYCLES + 4 * FRAME_CYCLES;

  logic   clk;
  logic   reset;
  byte_t  address;
  byte_t  wdata;
  logic   write;
  byte_t  rdata;
  logic   hpaddle;
  logic   vpaddle;
  logic   hsync;
  logic   vsync;
  pixel_t rgb;
  logic   done;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  end

  frame_buffer_top #(
    .H_ACTIVE     (H_ACTIVE),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_ACTIVE     (V_ACTIVE),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL),
    .PIX_AW       (PIX_AW)
  ) uut (
    .clk     (clk),
    .reset   (reset),
    .address (address),
    .wdata   (wdata),
    .write   (write),
    .rdata   (rdata),
    .hpaddle (hpaddle),
    .vpaddle (vpaddle),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

  fb_tests #(
    .H_ACTIVE       (H_ACTIVE),
    .H_SYNC_START   (H_SYNC_START),
    .H_SYNC_END     (H_SYNC_END),
    .H_TOTAL        (H_TOTAL),
    .V_ACTIVE       (V_ACTIVE),
    .V_SYNC_START   (V_SYNC_START),
    .V_SYNC_END     (V_SYNC_END),
    .V_TOTAL        (V_TOTAL),
    .PIX_AW         (PIX_AW),
    .BEAM_READS     (BEAM_READS),
    .RAM_OPS        (RAM_OPS),
    .UNMAPPED_READS (UNMAPPED_READS),
    .CURSOR_STEPS   (CURSOR_STEPS),
    .PAIR_COUNT     (PAIR_COUNT)
  ) tests (
    .clk     (clk),
    .reset   (reset),
    .address (address),
    .wdata   (wdata),
    .write   (write),
    .rdata   (rdata),
    .hpaddle (hpaddle),
    .vpaddle (vpaddle),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb),
    .done    (done)
  );

  task automatic check_byte(byte_t got, byte_t expected, string what);
    if (got !== expected) begin
      $display("[FAIL] %0t ns: %s got %02h, expected %02h", $time, what, got, expected);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_pixel(pixel_t got, pixel_t expected, string what);
    if (got !== expected) begin
      $display("[FAIL] %0t ns: %s got %01h, expected %01h", $time, what, got, expected);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  initial begin
    wait (done === 1'b1);
    $display("all tests passed");
    $finish;
  end

  // Budget covers every test plus four spare frames
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
